// ==== hw/ctrlStagePipe.sv ====
/*
 * Control registers for execute, memory and writeback.
 * Execute loads a bubble on flushE_i; memory and writeback never stall
 * and clear only on reset.
 */
module ctrlStagePipe (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flushE_i,
    // Decode-stage control
    input  logic                    regWriteD_i,
    input  logic                    aluSrcD_i,
    input  logic                    memWriteD_i,
    input  logic                    branchD_i,
    input  logic                    jumpD_i,
    input  logic                    branchTypeD_i,
    input  pipeCtrlPkg::resultSrcT  resultSrcD_i,
    input  pipeCtrlPkg::aluCtrlT    aluControlD_i,
    // Execute stage
    output pipeCtrlPkg::aluCtrlT    aluControlE_o,
    output logic                    aluSrcE_o,
    output logic                    branchE_o,
    output logic                    jumpE_o,
    output logic                    branchTypeE_o,
    output pipeCtrlPkg::resultSrcT  resultSrcE_o,
    // Memory stage
    output logic                    memWriteM_o,
    output pipeCtrlPkg::resultSrcT  resultSrcM_o,
    output logic                    regWriteM_o,
    // Writeback stage
    output logic                    regWriteW_o,
    output pipeCtrlPkg::resultSrcT  resultSrcW_o
);

    // Execute-stage bits not seen outside
    logic regWriteE;
    logic memWriteE;

    // Execute bank
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            regWriteE     <= 1'b0;
            memWriteE     <= 1'b0;
            resultSrcE_o  <= pipeCtrlPkg::resAlu;
            aluControlE_o <= pipeCtrlPkg::aluAdd;
            aluSrcE_o     <= 1'b0;
            branchE_o     <= 1'b0;
            jumpE_o       <= 1'b0;
            branchTypeE_o <= 1'b0;
        end else begin
            regWriteE     <= regWriteD_i;
            memWriteE     <= memWriteD_i;
            resultSrcE_o  <= resultSrcD_i;
            aluControlE_o <= aluControlD_i;
            aluSrcE_o     <= aluSrcD_i;
            branchE_o     <= branchD_i;
            jumpE_o       <= jumpD_i;
            branchTypeE_o <= branchTypeD_i;
        end
    end

    // Memory bank
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM_o  <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= pipeCtrlPkg::resAlu;
        end else begin
            regWriteM_o  <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM_o <= resultSrcE_o;
        end
    end

    // Writeback bank
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= pipeCtrlPkg::resAlu;
        end else begin
            regWriteW_o  <= regWriteM_o;
            resultSrcW_o <= resultSrcM_o;
        end
    end

endmodule

// ==== hw/hazardUnit.sv ====
/*
 * Forwarding, load-use stall, fetch-ready stall and mispredict flush.
 * All outputs are combinational. Data memory is assumed always ready.
 */
module hazardUnit (
    input  logic                    clk,
    input  logic                    reset,
    input  rvIsaPkg::regAddrT       rs1D_i,
    input  rvIsaPkg::regAddrT       rs2D_i,
    input  rvIsaPkg::regAddrT       rs1E_i,
    input  rvIsaPkg::regAddrT       rs2E_i,
    input  rvIsaPkg::regAddrT       rdE_i,
    input  rvIsaPkg::regAddrT       rdM_i,
    input  rvIsaPkg::regAddrT       rdW_i,
    input  pipeCtrlPkg::resultSrcT  resultSrcE_i,
    input  logic                    regWriteM_i,
    input  logic                    regWriteW_i,
    input  logic                    instrReady_i,
    input  logic                    mispredictE_i,
    output pipeCtrlPkg::forwardSelT forwardAE_o,
    output pipeCtrlPkg::forwardSelT forwardBE_o,
    output logic                    stallF_o,
    output logic                    stallD_o,
    output logic                    flushD_o,
    output logic                    flushE_o
);

    // Low only in the reset cycle
    logic fetchStarted;
    logic loadUseStall;

    // Memory stage wins over writeback, x0 is never forwarded
    function automatic pipeCtrlPkg::forwardSelT fwdSelect(
        input rvIsaPkg::regAddrT rsE,
        input rvIsaPkg::regAddrT rdM,
        input logic              regWriteM,
        input rvIsaPkg::regAddrT rdW,
        input logic              regWriteW
    );
        pipeCtrlPkg::forwardSelT sel;
        sel = pipeCtrlPkg::fwdReg;
        if (rsE != '0 && rsE == rdM && regWriteM) begin
            sel = pipeCtrlPkg::fwdMem;
        end else if (rsE != '0 && rsE == rdW && regWriteW) begin
            sel = pipeCtrlPkg::fwdWb;
        end
        return sel;
    endfunction

    assign forwardAE_o = fwdSelect(rs1E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);
    assign forwardBE_o = fwdSelect(rs2E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);

    // Fetch has no valid request pending during reset
    always_ff @(posedge clk) begin
        if (reset) begin
            fetchStarted <= 1'b0;
        end else begin
            fetchStarted <= 1'b1;
        end
    end

    // Load in execute feeding a source of the instruction in decode
    assign loadUseStall = (resultSrcE_i == pipeCtrlPkg::resMem)
                       && (rdE_i != '0)
                       && ((rdE_i == rs1D_i) || (rdE_i == rs2D_i));

    assign stallF_o = loadUseStall || (fetchStarted && !instrReady_i);
    assign stallD_o = loadUseStall || !instrReady_i;
    assign flushD_o = mispredictE_i;
    // Bubble into execute whenever decode holds or is squashed
    assign flushE_o = loadUseStall || mispredictE_i || !instrReady_i;

endmodule

// ==== hw/instrDecoder.sv ====
/*
 * Decode-stage control, purely combinational.
 * Unsupported opcodes give no register write, store, branch or jump.
 * Unsupported ALU funct3 values fall back to add.
 */
module instrDecoder (
    input  rvIsaPkg::opcodeT        op_i,
    input  rvIsaPkg::funct3T        funct3_i,
    input  logic                    funct7b5_i,
    output logic                    regWriteD_o,
    output logic                    aluSrcD_o,
    output logic                    memWriteD_o,
    output logic                    branchD_o,
    output logic                    jumpD_o,
    output logic                    branchTypeD_o,
    output pipeCtrlPkg::resultSrcT  resultSrcD_o,
    output pipeCtrlPkg::immSrcT     immSrcD_o,
    output pipeCtrlPkg::aluCtrlT    aluControlD_o
);

    // Class of ALU work, main decoder to ALU decoder
    pipeCtrlPkg::aluOpT aluOp;
    // R-type with funct7[5] set means sub
    logic rtypeSub;

    // Main decoder
    always_comb begin
        // Safe defaults, also the unknown-opcode result
        regWriteD_o  = 1'b0;
        immSrcD_o    = pipeCtrlPkg::immI;
        aluSrcD_o    = 1'b0;
        memWriteD_o  = 1'b0;
        resultSrcD_o = pipeCtrlPkg::resAlu;
        branchD_o    = 1'b0;
        jumpD_o      = 1'b0;
        aluOp        = pipeCtrlPkg::aluOpMem;
        case (op_i)
            rvIsaPkg::opLoad: begin
                regWriteD_o  = 1'b1;
                aluSrcD_o    = 1'b1;
                resultSrcD_o = pipeCtrlPkg::resMem;
            end
            rvIsaPkg::opStore: begin
                immSrcD_o   = pipeCtrlPkg::immS;
                aluSrcD_o   = 1'b1;
                memWriteD_o = 1'b1;
            end
            rvIsaPkg::opRtype: begin
                regWriteD_o = 1'b1;
                aluOp       = pipeCtrlPkg::aluOpFunct;
            end
            rvIsaPkg::opBranch: begin
                immSrcD_o = pipeCtrlPkg::immB;
                branchD_o = 1'b1;
                aluOp     = pipeCtrlPkg::aluOpBranch;
            end
            rvIsaPkg::opItypeAlu: begin
                regWriteD_o = 1'b1;
                aluSrcD_o   = 1'b1;
                aluOp       = pipeCtrlPkg::aluOpFunct;
            end
            rvIsaPkg::opJal: begin
                regWriteD_o  = 1'b1;
                immSrcD_o    = pipeCtrlPkg::immJ;
                resultSrcD_o = pipeCtrlPkg::resPc4;
                jumpD_o      = 1'b1;
            end
            rvIsaPkg::opJalr: begin
                // Target is rs1 + imm, so ALU takes the immediate
                regWriteD_o  = 1'b1;
                aluSrcD_o    = 1'b1;
                resultSrcD_o = pipeCtrlPkg::resPc4;
                jumpD_o      = 1'b1;
            end
            rvIsaPkg::opLui: begin
                regWriteD_o  = 1'b1;
                immSrcD_o    = pipeCtrlPkg::immU;
                resultSrcD_o = pipeCtrlPkg::resImm;
            end
            default: begin
                // Keep defaults
                regWriteD_o = 1'b0;
            end
        endcase
    end

    // I-type has op[5] clear, so addi with imm[10] set stays add
    assign rtypeSub = funct7b5_i & op_i[5];

    // ALU decoder
    always_comb begin
        case (aluOp)
            pipeCtrlPkg::aluOpMem:    aluControlD_o = pipeCtrlPkg::aluAdd;
            // Compare by subtraction, zero flag checked in datapath
            pipeCtrlPkg::aluOpBranch: aluControlD_o = pipeCtrlPkg::aluSub;
            pipeCtrlPkg::aluOpFunct: begin
                case (funct3_i)
                    rvIsaPkg::f3AddSub: begin
                        aluControlD_o = rtypeSub ? pipeCtrlPkg::aluSub : pipeCtrlPkg::aluAdd;
                    end
                    rvIsaPkg::f3Slt: aluControlD_o = pipeCtrlPkg::aluSlt;
                    rvIsaPkg::f3Or:  aluControlD_o = pipeCtrlPkg::aluOr;
                    rvIsaPkg::f3And: aluControlD_o = pipeCtrlPkg::aluAnd;
                    default:         aluControlD_o = pipeCtrlPkg::aluAdd;
                endcase
            end
            default: aluControlD_o = pipeCtrlPkg::aluAdd;
        endcase
    end

    // Branch-type decoder, high inverts the zero test for bne
    always_comb begin
        branchTypeD_o = 1'b0;
        if (op_i == rvIsaPkg::opBranch) begin
            case (funct3_i)
                rvIsaPkg::f3Beq: branchTypeD_o = 1'b0;
                rvIsaPkg::f3Bne: branchTypeD_o = 1'b1;
                default:         branchTypeD_o = 1'b0;
            endcase
        end
    end

endmodule

// ==== hw/pipeCtrlPkg.sv ====
/*
 * Control encodings passed between pipeline stages and to the datapath.
 * The datapath must decode immSrc, aluCtrl, resultSrc and forward selects
 * with exactly these values.
 */
package pipeCtrlPkg;

    // Immediate format select
    typedef logic [2:0] immSrcT;
    localparam immSrcT immI = 3'b000;
    localparam immSrcT immS = 3'b001;
    localparam immSrcT immB = 3'b010;
    localparam immSrcT immJ = 3'b011;
    localparam immSrcT immU = 3'b100;

    // ALU operation
    typedef logic [2:0] aluCtrlT;
    localparam aluCtrlT aluAdd = 3'b000;
    localparam aluCtrlT aluSub = 3'b001;
    localparam aluCtrlT aluAnd = 3'b010;
    localparam aluCtrlT aluOr  = 3'b011;
    localparam aluCtrlT aluSlt = 3'b101;

    // Main decoder to ALU decoder class
    typedef logic [1:0] aluOpT;
    localparam aluOpT aluOpMem    = 2'b00;
    localparam aluOpT aluOpBranch = 2'b01;
    localparam aluOpT aluOpFunct  = 2'b10;

    // Writeback result mux
    typedef logic [1:0] resultSrcT;
    localparam resultSrcT resAlu = 2'b00;
    localparam resultSrcT resMem = 2'b01;
    localparam resultSrcT resPc4 = 2'b10;
    localparam resultSrcT resImm = 2'b11;

    // Execute operand forwarding
    typedef logic [1:0] forwardSelT;
    localparam forwardSelT fwdReg = 2'b00;
    localparam forwardSelT fwdWb  = 2'b01;
    localparam forwardSelT fwdMem = 2'b10;

endpackage

// ==== hw/pipeCtrl_macros.svh ====
/*
 * Field widths of the RV32I instruction encoding used by the controller.
 * Only the fields the control path looks at are given here.
 */
`ifndef PIPE_CTRL_MACROS_SVH
`define PIPE_CTRL_MACROS_SVH

// Major opcode, instr[6:0]
`define RV_OPCODE_W 7

// Minor opcode, instr[14:12]
`define RV_FUNCT3_W 3

// Register index, 32 architectural registers
`define RV_REG_ADDR_W 5

`endif

// ==== hw/pipelineController.sv ====
/*
 * Control path of a five-stage RV32I-subset pipeline.
 * The datapath supplies instruction fields, register indices, fetch ready
 * and branch resolution; it consumes the control and hazard outputs.
 */
module pipelineController (
    input  logic                    clk,
    input  logic                    reset,
    // Decode-stage instruction fields
    input  rvIsaPkg::opcodeT        op_i,
    input  rvIsaPkg::funct3T        funct3_i,
    input  logic                    funct7b5_i,
    input  rvIsaPkg::regAddrT       rs1D_i,
    input  rvIsaPkg::regAddrT       rs2D_i,
    // Later-stage register indices
    input  rvIsaPkg::regAddrT       rs1E_i,
    input  rvIsaPkg::regAddrT       rs2E_i,
    input  rvIsaPkg::regAddrT       rdE_i,
    input  rvIsaPkg::regAddrT       rdM_i,
    input  rvIsaPkg::regAddrT       rdW_i,
    input  logic                    instrReady_i,
    input  logic                    mispredictE_i,
    // Decode
    output pipeCtrlPkg::immSrcT     immSrcD_o,
    // Execute
    output pipeCtrlPkg::aluCtrlT    aluControlE_o,
    output logic                    aluSrcE_o,
    output logic                    branchE_o,
    output logic                    jumpE_o,
    output logic                    branchTypeE_o,
    // Memory and writeback
    output logic                    memWriteM_o,
    output pipeCtrlPkg::resultSrcT  resultSrcM_o,
    output logic                    regWriteW_o,
    output pipeCtrlPkg::resultSrcT  resultSrcW_o,
    // Hazards
    output pipeCtrlPkg::forwardSelT forwardAE_o,
    output pipeCtrlPkg::forwardSelT forwardBE_o,
    output logic                    stallF_o,
    output logic                    stallD_o,
    output logic                    flushD_o,
    output logic                    flushE_o
);

    // Decode-stage control bundle
    logic                   regWriteD;
    logic                   aluSrcD;
    logic                   memWriteD;
    logic                   branchD;
    logic                   jumpD;
    logic                   branchTypeD;
    pipeCtrlPkg::resultSrcT resultSrcD;
    pipeCtrlPkg::aluCtrlT   aluControlD;
    // Stage pipe to hazard unit
    pipeCtrlPkg::resultSrcT resultSrcE;
    logic                   regWriteM;

    instrDecoder instrDecoder_inst (
        .op_i          (op_i),
        .funct3_i      (funct3_i),
        .funct7b5_i    (funct7b5_i),
        .regWriteD_o   (regWriteD),
        .aluSrcD_o     (aluSrcD),
        .memWriteD_o   (memWriteD),
        .branchD_o     (branchD),
        .jumpD_o       (jumpD),
        .branchTypeD_o (branchTypeD),
        .resultSrcD_o  (resultSrcD),
        .immSrcD_o     (immSrcD_o),
        .aluControlD_o (aluControlD)
    );

    ctrlStagePipe ctrlStagePipe_inst (
        .clk           (clk),
        .reset         (reset),
        .flushE_i      (flushE_o),
        .regWriteD_i   (regWriteD),
        .aluSrcD_i     (aluSrcD),
        .memWriteD_i   (memWriteD),
        .branchD_i     (branchD),
        .jumpD_i       (jumpD),
        .branchTypeD_i (branchTypeD),
        .resultSrcD_i  (resultSrcD),
        .aluControlD_i (aluControlD),
        .aluControlE_o (aluControlE_o),
        .aluSrcE_o     (aluSrcE_o),
        .branchE_o     (branchE_o),
        .jumpE_o       (jumpE_o),
        .branchTypeE_o (branchTypeE_o),
        .resultSrcE_o  (resultSrcE),
        .memWriteM_o   (memWriteM_o),
        .resultSrcM_o  (resultSrcM_o),
        .regWriteM_o   (regWriteM),
        .regWriteW_o   (regWriteW_o),
        .resultSrcW_o  (resultSrcW_o)
    );

    hazardUnit hazardUnit_inst (
        .clk           (clk),
        .reset         (reset),
        .rs1D_i        (rs1D_i),
        .rs2D_i        (rs2D_i),
        .rs1E_i        (rs1E_i),
        .rs2E_i        (rs2E_i),
        .rdE_i         (rdE_i),
        .rdM_i         (rdM_i),
        .rdW_i         (rdW_i),
        .resultSrcE_i  (resultSrcE),
        .regWriteM_i   (regWriteM),
        .regWriteW_i   (regWriteW_o),
        .instrReady_i  (instrReady_i),
        .mispredictE_i (mispredictE_i),
        .forwardAE_o   (forwardAE_o),
        .forwardBE_o   (forwardBE_o),
        .stallF_o      (stallF_o),
        .stallD_o      (stallD_o),
        .flushD_o      (flushD_o),
        .flushE_o      (flushE_o)
    );

endmodule

// ==== hw/rvIsaPkg.sv ====
/*
 * RV32I subset seen by the controller: lw, sw, R-type, I-type ALU,
 * beq/bne, jal, jalr and lui. Anything else decodes as a no-op.
 */
`include "pipeCtrl_macros.svh"

package rvIsaPkg;

    // Instruction field types
    typedef logic [`RV_OPCODE_W-1:0]   opcodeT;
    typedef logic [`RV_FUNCT3_W-1:0]   funct3T;
    typedef logic [`RV_REG_ADDR_W-1:0] regAddrT;

    // Major opcodes
    localparam opcodeT opLoad     = 7'b0000011;
    localparam opcodeT opStore    = 7'b0100011;
    localparam opcodeT opRtype    = 7'b0110011;
    localparam opcodeT opBranch   = 7'b1100011;
    localparam opcodeT opItypeAlu = 7'b0010011;
    localparam opcodeT opJal      = 7'b1101111;
    localparam opcodeT opJalr     = 7'b1100111;
    localparam opcodeT opLui      = 7'b0110111;

    // ALU funct3, shared by R-type and I-type
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // Branch funct3
    localparam funct3T f3Beq = 3'b000;
    localparam funct3T f3Bne = 3'b001;

endpackage

// ==== pipelineController.f ====
+incdir+hw
hw/rvIsaPkg.sv
hw/pipeCtrlPkg.sv
hw/instrDecoder.sv
hw/ctrlStagePipe.sv
hw/hazardUnit.sv
hw/pipelineController.sv
verification/pipelineController_props.sv
verification/pipelineControllerTb.sv

// ==== verification/pipelineControllerTb.sv ====
/*
 * Random instruction stream for pipelineController. Checks live in the bound props.
 * Stimulus comes from a 32-bit Fibonacci LFSR. Register indices stay within x0..x3.
 */
module pipelineControllerTb;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 8;
    localparam int numCycles   = 4000;
    localparam int drainCycles = 6;

    logic                    clk;
    logic                    reset;
    rvIsaPkg::opcodeT        op_i;
    rvIsaPkg::funct3T        funct3_i;
    logic                    funct7b5_i;
    rvIsaPkg::regAddrT       rs1D_i;
    rvIsaPkg::regAddrT       rs2D_i;
    rvIsaPkg::regAddrT       rs1E_i;
    rvIsaPkg::regAddrT       rs2E_i;
    rvIsaPkg::regAddrT       rdE_i;
    rvIsaPkg::regAddrT       rdM_i;
    rvIsaPkg::regAddrT       rdW_i;
    logic                    instrReady_i;
    logic                    mispredictE_i;
    pipeCtrlPkg::immSrcT     immSrcD_o;
    pipeCtrlPkg::aluCtrlT    aluControlE_o;
    logic                    aluSrcE_o;
    logic                    branchE_o;
    logic                    jumpE_o;
    logic                    branchTypeE_o;
    logic                    memWriteM_o;
    pipeCtrlPkg::resultSrcT  resultSrcM_o;
    logic                    regWriteW_o;
    pipeCtrlPkg::resultSrcT  resultSrcW_o;
    pipeCtrlPkg::forwardSelT forwardAE_o;
    pipeCtrlPkg::forwardSelT forwardBE_o;
    logic                    stallF_o;
    logic                    stallD_o;
    logic                    flushD_o;
    logic                    flushE_o;
    logic [31:0]             lfsrState;

    pipelineController pipelineController_inst (
        .clk           (clk),
        .reset         (reset),
        .op_i          (op_i),
        .funct3_i      (funct3_i),
        .funct7b5_i    (funct7b5_i),
        .rs1D_i        (rs1D_i),
        .rs2D_i        (rs2D_i),
        .rs1E_i        (rs1E_i),
        .rs2E_i        (rs2E_i),
        .rdE_i         (rdE_i),
        .rdM_i         (rdM_i),
        .rdW_i         (rdW_i),
        .instrReady_i  (instrReady_i),
        .mispredictE_i (mispredictE_i),
        .immSrcD_o     (immSrcD_o),
        .aluControlE_o (aluControlE_o),
        .aluSrcE_o     (aluSrcE_o),
        .branchE_o     (branchE_o),
        .jumpE_o       (jumpE_o),
        .branchTypeE_o (branchTypeE_o),
        .memWriteM_o   (memWriteM_o),
        .resultSrcM_o  (resultSrcM_o),
        .regWriteW_o   (regWriteW_o),
        .resultSrcW_o  (resultSrcW_o),
        .forwardAE_o   (forwardAE_o),
        .forwardBE_o   (forwardBE_o),
        .stallF_o      (stallF_o),
        .stallD_o      (stallD_o),
        .flushD_o      (flushD_o),
        .flushE_o      (flushE_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic stepLfsr();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], stepLfsr()};
        end
        return bits;
    endfunction

    // One supported opcode per slot
    function automatic rvIsaPkg::opcodeT opcodeAt(input logic [2:0] idx);
        case (idx)
            3'd0:    return rvIsaPkg::opLoad;
            3'd1:    return rvIsaPkg::opStore;
            3'd2:    return rvIsaPkg::opRtype;
            3'd3:    return rvIsaPkg::opItypeAlu;
            3'd4:    return rvIsaPkg::opBranch;
            3'd5:    return rvIsaPkg::opJal;
            3'd6:    return rvIsaPkg::opJalr;
            default: return rvIsaPkg::opLui;
        endcase
    endfunction

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    // One decode slot with every field changed on the falling edge
    task automatic driveRandomCycle();
        logic [2:0] idx;
        @(negedge clk);
        idx = 3'(takeBits(3));
        // Roughly one in eight is an unsupported opcode (fence)
        op_i          = (takeBits(3) == 0) ? 7'b0001111 : opcodeAt(idx);
        funct3_i      = 3'(takeBits(3));
        funct7b5_i    = 1'(takeBits(1));
        rs1D_i        = 5'(takeBits(2));
        rs2D_i        = 5'(takeBits(2));
        rs1E_i        = 5'(takeBits(2));
        rs2E_i        = 5'(takeBits(2));
        rdE_i         = 5'(takeBits(2));
        rdM_i         = 5'(takeBits(2));
        rdW_i         = 5'(takeBits(2));
        instrReady_i  = (takeBits(3) != 0);
        mispredictE_i = (takeBits(4) == 0);
    endtask

    // Any failed assertion ends the run
    always @(pipelineController_inst.ctrlProps.failCount) begin
        if (pipelineController_inst.ctrlProps.failCount != 0) begin
            reportFailure("Assertion check failed, see error above");
        end
    end

    initial begin
        #((resetCycles + numCycles + drainCycles + 50) * clkPeriod);
        reportFailure("Timeout: watchdog expired before the stimulus finished");
    end

    initial begin
        lfsrState     = 32'h1b3d;
        reset         = 1'b1;
        op_i          = '0;
        funct3_i      = '0;
        funct7b5_i    = 1'b0;
        rs1D_i        = '0;
        rs2D_i        = '0;
        rs1E_i        = '0;
        rs2E_i        = '0;
        rdE_i         = '0;
        rdM_i         = '0;
        rdW_i         = '0;
        instrReady_i  = 1'b1;
        mispredictE_i = 1'b0;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        // Not ready in the first cycle while fetch has not started
        instrReady_i = 1'b0;
        repeat (numCycles) driveRandomCycle();
        repeat (drainCycles) @(negedge clk);
        if (pipelineController_inst.ctrlProps.failCount == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            reportFailure("Checks failed during the run");
        end
    end

endmodule

// ==== verification/pipelineController_props.sv ====
/*
 * Bound checker for pipelineController, reference models from the control rules.
 * Stage models are zeroed by reset and execute takes a bubble on the modelled flush.
 * failCount counts failed checks for the testbench to watch.
 */
module pipelineController_props (
    input logic                    clk,
    input logic                    reset,
    input rvIsaPkg::opcodeT        op_i,
    input rvIsaPkg::funct3T        funct3_i,
    input logic                    funct7b5_i,
    input rvIsaPkg::regAddrT       rs1D_i,
    input rvIsaPkg::regAddrT       rs2D_i,
    input rvIsaPkg::regAddrT       rs1E_i,
    input rvIsaPkg::regAddrT       rs2E_i,
    input rvIsaPkg::regAddrT       rdE_i,
    input rvIsaPkg::regAddrT       rdM_i,
    input rvIsaPkg::regAddrT       rdW_i,
    input logic                    instrReady_i,
    input logic                    mispredictE_i,
    input pipeCtrlPkg::immSrcT     immSrcD_o,
    input pipeCtrlPkg::aluCtrlT    aluControlE_o,
    input logic                    aluSrcE_o,
    input logic                    branchE_o,
    input logic                    jumpE_o,
    input logic                    branchTypeE_o,
    input logic                    memWriteM_o,
    input pipeCtrlPkg::resultSrcT  resultSrcM_o,
    input logic                    regWriteW_o,
    input pipeCtrlPkg::resultSrcT  resultSrcW_o,
    input pipeCtrlPkg::forwardSelT forwardAE_o,
    input pipeCtrlPkg::forwardSelT forwardBE_o,
    input logic                    stallF_o,
    input logic                    stallD_o,
    input logic                    flushD_o,
    input logic                    flushE_o
);

    // Control word layout
    // [13] regWrite [12] aluSrc [11] memWrite [10] branch [9] jump
    // [8] branchType [7:6] resultSrc [5:3] immSrc [2:0] aluCtrl
    logic [13:0] ctrlD;
    logic [13:0] ctrlE;
    logic [13:0] ctrlM;
    logic [13:0] ctrlW;
    logic        fetchStartedRef;
    logic        loadUseRef;
    logic        flushERef;
    logic [6:0]  execOut;
    logic [6:0]  execRef;
    int          failCount = 0;

    // ALU op for funct3, sub only on R-type with funct7[5]
    function automatic pipeCtrlPkg::aluCtrlT aluFromFunct(
        input rvIsaPkg::funct3T f3,
        input logic             subSel
    );
        case (f3)
            3'b000:  return subSel ? pipeCtrlPkg::aluSub : pipeCtrlPkg::aluAdd;
            3'b010:  return pipeCtrlPkg::aluSlt;
            3'b110:  return pipeCtrlPkg::aluOr;
            3'b111:  return pipeCtrlPkg::aluAnd;
            default: return pipeCtrlPkg::aluAdd;
        endcase
    endfunction

    // Expected decode table
    function automatic logic [13:0] expectedDecode(
        input rvIsaPkg::opcodeT op,
        input rvIsaPkg::funct3T f3,
        input logic             f7b5
    );
        logic [4:0]             flags;
        logic                   bne;
        pipeCtrlPkg::resultSrcT res;
        pipeCtrlPkg::immSrcT    imm;
        pipeCtrlPkg::aluCtrlT   alu;
        // flags: regWrite aluSrc memWrite branch jump
        flags = 5'b00000;
        bne   = 1'b0;
        res   = pipeCtrlPkg::resAlu;
        imm   = pipeCtrlPkg::immI;
        alu   = pipeCtrlPkg::aluAdd;
        case (op)
            7'b0000011: begin
                flags = 5'b11000;
                res   = pipeCtrlPkg::resMem;
            end
            7'b0100011: begin
                flags = 5'b01100;
                imm   = pipeCtrlPkg::immS;
            end
            7'b0110011: begin
                flags = 5'b10000;
                alu   = aluFromFunct(f3, f7b5);
            end
            7'b0010011: begin
                flags = 5'b11000;
                alu   = aluFromFunct(f3, 1'b0);
            end
            7'b1100011: begin
                flags = 5'b00010;
                imm   = pipeCtrlPkg::immB;
                alu   = pipeCtrlPkg::aluSub;
                bne   = (f3 == 3'b001);
            end
            7'b1101111: begin
                flags = 5'b10001;
                imm   = pipeCtrlPkg::immJ;
                res   = pipeCtrlPkg::resPc4;
            end
            7'b1100111: begin
                flags = 5'b11001;
                res   = pipeCtrlPkg::resPc4;
            end
            7'b0110111: begin
                flags = 5'b10000;
                imm   = pipeCtrlPkg::immU;
                res   = pipeCtrlPkg::resImm;
            end
            default: begin
                flags = 5'b00000;
            end
        endcase
        return {flags, bne, res, imm, alu};
    endfunction

    // Memory before writeback, x0 never
    function automatic pipeCtrlPkg::forwardSelT expectedForward(
        input rvIsaPkg::regAddrT rs,
        input rvIsaPkg::regAddrT rdM,
        input logic              wrM,
        input rvIsaPkg::regAddrT rdW,
        input logic              wrW
    );
        if (rs != 5'd0 && rs == rdM && wrM) begin
            return pipeCtrlPkg::fwdMem;
        end
        if (rs != 5'd0 && rs == rdW && wrW) begin
            return pipeCtrlPkg::fwdWb;
        end
        return pipeCtrlPkg::fwdReg;
    endfunction

    assign ctrlD      = expectedDecode(op_i, funct3_i, funct7b5_i);
    assign loadUseRef = (ctrlE[7:6] == pipeCtrlPkg::resMem) && (rdE_i != 5'd0)
                     && ((rdE_i == rs1D_i) || (rdE_i == rs2D_i));
    assign flushERef  = loadUseRef || mispredictE_i || !instrReady_i;
    assign execOut    = {aluControlE_o, aluSrcE_o, branchE_o, jumpE_o, branchTypeE_o};
    assign execRef    = {ctrlE[2:0], ctrlE[12], ctrlE[10], ctrlE[9], ctrlE[8]};

    // Stage model
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlE           <= '0;
            ctrlM           <= '0;
            ctrlW           <= '0;
            fetchStartedRef <= 1'b0;
        end else begin
            ctrlE           <= flushERef ? 14'd0 : ctrlD;
            ctrlM           <= ctrlE;
            ctrlW           <= ctrlM;
            fetchStartedRef <= 1'b1;
        end
    end

    // Decode is same cycle
    assert property (@(posedge clk) disable iff (reset) immSrcD_o == ctrlD[5:3])
        else begin
            $error("MISMATCH at %0t: immSrcD_o %0h, expected %0h", $time, immSrcD_o, ctrlD[5:3]);
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset) execOut == execRef)
        else begin
            $error("MISMATCH at %0t: execute controls %0h, expected %0h", $time, execOut, execRef);
            failCount++;
        end

    // Load-use gives a bubble next cycle
    assert property (@(posedge clk) disable iff (reset) loadUseRef |=> execOut == 7'd0)
        else begin
            $error("MISMATCH at %0t: execute not bubbled after load-use", $time);
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset)
            {memWriteM_o, resultSrcM_o} == {ctrlM[11], ctrlM[7:6]})
        else begin
            $error("MISMATCH at %0t: memory stage %b%b, expected %b%b", $time,
                   memWriteM_o, resultSrcM_o, ctrlM[11], ctrlM[7:6]);
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset)
            {regWriteW_o, resultSrcW_o} == {ctrlW[13], ctrlW[7:6]})
        else begin
            $error("MISMATCH at %0t: writeback stage %b%b, expected %b%b", $time,
                   regWriteW_o, resultSrcW_o, ctrlW[13], ctrlW[7:6]);
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset)
            forwardAE_o == expectedForward(rs1E_i, rdM_i, ctrlM[13], rdW_i, ctrlW[13]))
        else begin
            $error("MISMATCH at %0t: forwardAE_o %0d wrong for rs1E %0d", $time,
                   forwardAE_o, rs1E_i);
            failCount++;
        end

    assert property (@(posedge clk) disable iff (reset)
            forwardBE_o == expectedForward(rs2E_i, rdM_i, ctrlM[13], rdW_i, ctrlW[13]))
        else begin
            $error("MISMATCH at %0t: forwardBE_o %0d wrong for rs2E %0d", $time,
                   forwardBE_o, rs2E_i);
            failCount++;
        end

    // Stall and flush equations
    assert property (@(posedge clk) disable iff (reset)
            {stallF_o, stallD_o, flushD_o, flushE_o} ==
            {loadUseRef || (fetchStartedRef && !instrReady_i),
             loadUseRef || !instrReady_i, mispredictE_i, flushERef})
        else begin
            $error("MISMATCH at %0t: stallF/stallD/flushD/flushE %b%b%b%b", $time,
                   stallF_o, stallD_o, flushD_o, flushE_o);
            failCount++;
        end

    // First cycle out of reset, all registered outputs clear
    assert property (@(posedge clk) $fell(reset) |->
            (execOut == 7'd0) && !memWriteM_o && (resultSrcM_o == 2'd0)
            && !regWriteW_o && (resultSrcW_o == 2'd0))
        else begin
            $error("MISMATCH at %0t: registered outputs not zero after reset", $time);
            failCount++;
        end

endmodule

bind pipelineController pipelineController_props ctrlProps (.*);
